// ==== common/mips_pkg.sv ====
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_BLEZ  = 6'h06,
        OP_BGTZ  = 6'h07,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_GTZ,
        BR_LEZ,
        BR_JUMP_IMM,
        BR_JUMP_REG
    } branch_kind_t;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXECUTE,
        ST_MEMORY
    } cpu_state_t;

    typedef struct packed {
        alu_op_t      alu_op;
        logic         src_b_imm;   // Immediate instead of rt
        logic         use_shamt;
        word_t        imm;         // Already extended
        reg_addr_t    dest;
        logic         reg_write;
        logic         link;        // Write pc+4 instead of result
        logic         is_load;
        logic         is_store;
        branch_kind_t branch;
        logic [25:0]  jump_index;
    } decoded_t;

    parameter word_t RESET_VECTOR = 32'hBFC0_0000;
    parameter reg_addr_t LINK_REG = 5'd31;
    parameter reg_addr_t V0_REG = 5'd2;

endpackage

// ==== hdl/alu.sv ====
`timescale 1ns/1ns

module alu (
    input  mips_pkg::decoded_t dec,
    input  mips_pkg::word_t    rs_val,
    input  mips_pkg::word_t    rt_val,
    input  logic [4:0]         shamt,
    output mips_pkg::word_t    result,
    output logic               equal,
    output logic               rs_zero,
    output logic               rs_negative
);
    mips_pkg::word_t b;
    logic [4:0] shift;

    assign b = dec.src_b_imm ? dec.imm : rt_val;
    assign shift = dec.use_shamt ? shamt : 5'd0;

    always_comb begin
        case (dec.alu_op)
            mips_pkg::ALU_ADD:    result = rs_val + b;   // Also load/store address
            mips_pkg::ALU_SUB:    result = rs_val - b;
            mips_pkg::ALU_AND:    result = rs_val & b;
            mips_pkg::ALU_OR:     result = rs_val | b;
            mips_pkg::ALU_XOR:    result = rs_val ^ b;
            mips_pkg::ALU_SLT:    result = {31'd0, $signed(rs_val) < $signed(b)};
            mips_pkg::ALU_SLTU:   result = {31'd0, rs_val < b};
            mips_pkg::ALU_SLL:    result = b << shift;
            mips_pkg::ALU_SRL:    result = b >> shift;
            mips_pkg::ALU_PASS_B: result = b;
            default:              result = '0;
        endcase
    end

    // Branch compare flags
    assign equal = rs_val == rt_val;
    assign rs_zero = rs_val == '0;
    assign rs_negative = rs_val[31];

endmodule

// ==== hdl/bus_port.sv ====
`timescale 1ns/1ns

module bus_port (
    input  logic               bus_sel,
    input  mips_pkg::word_t    pc,
    input  mips_pkg::word_t    alu_result,
    input  mips_pkg::word_t    rt_val,
    input  mips_pkg::word_t    readdata,
    input  mips_pkg::decoded_t dec,
    output mips_pkg::word_t    address,
    output mips_pkg::word_t    writedata,
    output mips_pkg::word_t    instr,
    output mips_pkg::word_t    load_data,
    output mips_pkg::word_t    reg_wdata,
    output logic [3:0]         byteenable
);
    mips_pkg::word_t addr_raw;

    // Bus side is little-endian
    function automatic mips_pkg::word_t swap_bytes(input mips_pkg::word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    assign addr_raw = bus_sel ? alu_result : pc;
    assign address = {addr_raw[31:2], 2'b00};
    assign byteenable = 4'b1111;   // Word accesses only

    assign instr = swap_bytes(readdata);
    assign load_data = swap_bytes(readdata);
    assign writedata = swap_bytes(rt_val);

    always_comb begin
        if (dec.is_load) begin
            reg_wdata = load_data;
        end else if (dec.link) begin
            reg_wdata = pc;   // Already advanced past the jump
        end else begin
            reg_wdata = alu_result;
        end
    end

endmodule

// ==== hdl/cpu_fsm.sv ====
`timescale 1ns/1ns

module cpu_fsm (
    input  logic               clk,
    input  logic               reset,
    input  logic               waitrequest,
    input  mips_pkg::decoded_t dec,
    input  mips_pkg::word_t    pc,
    output logic               active,
    output logic               read,
    output logic               write,
    output logic               bus_sel,
    output logic               fetch_done,
    output logic               exec_step,
    output logic               mem_done,
    output logic               reg_we
);
    mips_pkg::cpu_state_t state;
    logic mem_access;

    assign mem_access = dec.is_load || dec.is_store;

    // Halted once the program counter reaches 0 between instructions
    assign active = !(state == mips_pkg::ST_FETCH && pc == '0);

    always_comb begin
        read = 1'b0;
        write = 1'b0;
        bus_sel = 1'b0;   // Fetch address
        case (state)
            mips_pkg::ST_FETCH: begin
                read = active && !reset;   // First read after reset release
            end
            mips_pkg::ST_MEMORY: begin
                read = dec.is_load;
                write = dec.is_store;
                bus_sel = 1'b1;   // Data address from ALU
            end
            default: begin
                read = 1'b0;
            end
        endcase
    end

    assign fetch_done = read && !bus_sel && !waitrequest;
    assign exec_step = state == mips_pkg::ST_EXECUTE;
    assign mem_done = state == mips_pkg::ST_MEMORY && !waitrequest;

    // Loads write back only once their data arrives
    assign reg_we = (exec_step && dec.reg_write && !mem_access)
                  || (mem_done && dec.is_load);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mips_pkg::ST_FETCH;
        end else begin
            case (state)
                mips_pkg::ST_FETCH: begin
                    if (fetch_done) begin
                        state <= mips_pkg::ST_EXECUTE;
                    end
                end
                mips_pkg::ST_EXECUTE: begin
                    state <= mem_access ? mips_pkg::ST_MEMORY : mips_pkg::ST_FETCH;
                end
                mips_pkg::ST_MEMORY: begin
                    if (mem_done) begin
                        state <= mips_pkg::ST_FETCH;
                    end
                end
                default: begin
                    state <= mips_pkg::ST_FETCH;
                end
            endcase
        end
    end

endmodule

// ==== hdl/instr_decode.sv ====
`timescale 1ns/1ns

module instr_decode (
    input  logic                clk,
    input  logic                reset,
    input  logic                fetch_done,
    input  mips_pkg::word_t     instr,
    output mips_pkg::decoded_t  dec,
    output mips_pkg::reg_addr_t rs,
    output mips_pkg::reg_addr_t rt,
    output logic [4:0]          shamt
);
    mips_pkg::word_t ir;
    mips_pkg::opcode_t opcode;
    mips_pkg::funct_t funct;
    mips_pkg::word_t imm_sign;
    mips_pkg::word_t imm_zero;

    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= '0;
        end else if (fetch_done) begin
            ir <= instr;
        end
    end

    assign opcode = mips_pkg::opcode_t'(ir[31:26]);
    assign funct = mips_pkg::funct_t'(ir[5:0]);
    assign rs = ir[25:21];
    assign rt = ir[20:16];
    assign shamt = ir[10:6];
    assign imm_sign = {{16{ir[15]}}, ir[15:0]};
    assign imm_zero = {16'h0000, ir[15:0]};

    always_comb begin
        dec = '0;   // Anything unknown stays a no-op
        dec.alu_op = mips_pkg::ALU_ADD;
        dec.imm = imm_sign;
        dec.dest = rt;
        dec.branch = mips_pkg::BR_NONE;
        dec.jump_index = ir[25:0];
        dec.src_b_imm = 1'b1;

        case (opcode)
            mips_pkg::OP_RTYPE: begin
                dec.src_b_imm = 1'b0;
                dec.dest = ir[15:11];
                dec.reg_write = 1'b1;
                case (funct)
                    mips_pkg::FN_ADDU: dec.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: dec.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  dec.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   dec.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  dec.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  dec.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLTU: dec.alu_op = mips_pkg::ALU_SLTU;
                    mips_pkg::FN_SLL: begin
                        dec.alu_op = mips_pkg::ALU_SLL;
                        dec.use_shamt = 1'b1;
                    end
                    mips_pkg::FN_SRL: begin
                        dec.alu_op = mips_pkg::ALU_SRL;
                        dec.use_shamt = 1'b1;
                    end
                    mips_pkg::FN_JR: begin
                        dec.branch = mips_pkg::BR_JUMP_REG;
                        dec.reg_write = 1'b0;
                    end
                    mips_pkg::FN_JALR: begin
                        dec.branch = mips_pkg::BR_JUMP_REG;
                        dec.link = 1'b1;
                    end
                    default: dec.reg_write = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: dec.reg_write = 1'b1;
            mips_pkg::OP_SLTI: begin
                dec.alu_op = mips_pkg::ALU_SLT;
                dec.reg_write = 1'b1;
            end
            mips_pkg::OP_ANDI: begin
                dec.alu_op = mips_pkg::ALU_AND;
                dec.imm = imm_zero;
                dec.reg_write = 1'b1;
            end
            mips_pkg::OP_ORI: begin
                dec.alu_op = mips_pkg::ALU_OR;
                dec.imm = imm_zero;
                dec.reg_write = 1'b1;
            end
            mips_pkg::OP_LUI: begin
                dec.alu_op = mips_pkg::ALU_PASS_B;
                dec.imm = {ir[15:0], 16'h0000};
                dec.reg_write = 1'b1;
            end
            mips_pkg::OP_LW: begin
                dec.is_load = 1'b1;
                dec.reg_write = 1'b1;
            end
            mips_pkg::OP_SW:   dec.is_store = 1'b1;
            mips_pkg::OP_BEQ:  dec.branch = mips_pkg::BR_EQ;
            mips_pkg::OP_BNE:  dec.branch = mips_pkg::BR_NE;
            mips_pkg::OP_BGTZ: dec.branch = mips_pkg::BR_GTZ;
            mips_pkg::OP_BLEZ: dec.branch = mips_pkg::BR_LEZ;
            mips_pkg::OP_J:    dec.branch = mips_pkg::BR_JUMP_IMM;
            mips_pkg::OP_JAL: begin
                dec.branch = mips_pkg::BR_JUMP_IMM;
                dec.link = 1'b1;
                dec.reg_write = 1'b1;
                dec.dest = mips_pkg::LINK_REG;
            end
            default: dec.reg_write = 1'b0;
        endcase
    end

endmodule

// ==== hdl/pc_counter.sv ====
`timescale 1ns/1ns

module pc_counter #(
    parameter mips_pkg::word_t reset_vector = mips_pkg::RESET_VECTOR
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               fetch_done,
    input  logic               exec_step,
    input  mips_pkg::decoded_t dec,
    input  mips_pkg::word_t    rs_val,
    input  logic               alu_equal,
    input  logic               rs_zero,
    input  logic               rs_negative,
    output mips_pkg::word_t    pc
);
    mips_pkg::word_t target;
    mips_pkg::word_t next_target;
    logic pending;
    logic taken;

    always_comb begin
        case (dec.branch)
            mips_pkg::BR_EQ:       taken = alu_equal;
            mips_pkg::BR_NE:       taken = !alu_equal;
            mips_pkg::BR_GTZ:      taken = !rs_negative && !rs_zero;
            mips_pkg::BR_LEZ:      taken = rs_negative || rs_zero;
            mips_pkg::BR_JUMP_IMM: taken = 1'b1;
            mips_pkg::BR_JUMP_REG: taken = 1'b1;
            default:               taken = 1'b0;
        endcase

        // pc already points at the delay slot here
        case (dec.branch)
            mips_pkg::BR_JUMP_IMM: next_target = {pc[31:28], dec.jump_index, 2'b00};
            mips_pkg::BR_JUMP_REG: next_target = rs_val;
            default:               next_target = pc + {dec.imm[29:0], 2'b00};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_vector;
            pending <= 1'b0;
        end else if (fetch_done) begin
            pc <= pc + 32'd4;
        end else if (exec_step) begin
            if (pending) begin   // Delay slot done, branches in it are ignored
                pc <= target;
                pending <= 1'b0;
            end else if (taken) begin
                target <= next_target;
                pending <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
    input  logic                clk,
    input  logic                reset,
    input  mips_pkg::reg_addr_t rs,
    input  mips_pkg::reg_addr_t rt,
    input  mips_pkg::reg_addr_t dest,
    input  logic                we,
    input  mips_pkg::word_t     wdata,
    output mips_pkg::word_t     rs_val,
    output mips_pkg::word_t     rt_val,
    output mips_pkg::word_t     register_v0
);
    mips_pkg::word_t regs [32];

    assign rs_val = regs[rs];
    assign rt_val = regs[rt];
    assign register_v0 = regs[mips_pkg::V0_REG];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && dest != '0) begin   // $zero never changes
            regs[dest] <= wdata;
        end
    end

endmodule

// ==== hdl/mips_cpu_bus.sv ====
`timescale 1ns/1ns

module mips_cpu_bus #(
    parameter mips_pkg::word_t reset_vector = mips_pkg::RESET_VECTOR
) (
    input  logic            clk,
    input  logic            reset,
    output logic            active,
    output mips_pkg::word_t register_v0,

    output mips_pkg::word_t address,
    output logic            write,
    output logic            read,
    input  logic            waitrequest,
    output mips_pkg::word_t writedata,
    output logic [3:0]      byteenable,
    input  mips_pkg::word_t readdata
);
    mips_pkg::decoded_t dec;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    logic [4:0] shamt;

    mips_pkg::word_t pc;
    mips_pkg::word_t instr;
    mips_pkg::word_t load_data;
    mips_pkg::word_t reg_wdata;
    mips_pkg::word_t rs_val;
    mips_pkg::word_t rt_val;
    mips_pkg::word_t alu_result;

    logic bus_sel;
    logic fetch_done;
    logic exec_step;
    logic reg_we;
    logic alu_equal;
    logic rs_zero;
    logic rs_negative;

    // Load completion is already folded into reg_we
    cpu_fsm cpu_fsm_i (.clk(clk), .reset(reset), .waitrequest(waitrequest), .dec(dec), .pc(pc),
        .active(active), .read(read), .write(write), .bus_sel(bus_sel),
        .fetch_done(fetch_done), .exec_step(exec_step), .mem_done(), .reg_we(reg_we));

    pc_counter #(.reset_vector(reset_vector)) pc_counter_i (.clk(clk), .reset(reset),
        .fetch_done(fetch_done), .exec_step(exec_step), .dec(dec), .rs_val(rs_val),
        .alu_equal(alu_equal), .rs_zero(rs_zero), .rs_negative(rs_negative), .pc(pc));

    instr_decode instr_decode_i (.clk(clk), .reset(reset), .fetch_done(fetch_done),
        .instr(instr), .dec(dec), .rs(rs), .rt(rt), .shamt(shamt));

    reg_file reg_file_i (.clk(clk), .reset(reset), .rs(rs), .rt(rt), .dest(dec.dest),
        .we(reg_we), .wdata(reg_wdata), .rs_val(rs_val), .rt_val(rt_val),
        .register_v0(register_v0));

    alu alu_i (.dec(dec), .rs_val(rs_val), .rt_val(rt_val), .shamt(shamt),
        .result(alu_result), .equal(alu_equal), .rs_zero(rs_zero),
        .rs_negative(rs_negative));

    bus_port bus_port_i (.bus_sel(bus_sel), .pc(pc), .alu_result(alu_result),
        .rt_val(rt_val), .readdata(readdata), .dec(dec), .address(address),
        .writedata(writedata), .instr(instr), .load_data(load_data),
        .reg_wdata(reg_wdata), .byteenable(byteenable));

endmodule

// ==== dv/bus_memory.sv ====
`timescale 1ns/1ns

module bus_memory #(
    parameter int seed = 90
) (
    input  logic            clk,
    input  int              stall_percent,
    input  mips_pkg::word_t address,
    input  logic            read,
    input  logic            write,
    input  mips_pkg::word_t writedata,
    output logic            waitrequest,
    output mips_pkg::word_t readdata
);
    // Words kept in bus byte order, aliased every 4 KB
    mips_pkg::word_t mem [1024];

    task automatic clear();
        foreach (mem[i]) begin
            mem[i] = '0;
        end
    endtask

    task automatic store_word(input mips_pkg::word_t addr, input mips_pkg::word_t data);
        mem[addr[11:2]] = data;
    endtask

    initial begin
        void'($urandom(seed));
        waitrequest = 1'b1;
        readdata = '0;
        forever begin
            @(negedge clk);
            waitrequest = int'($urandom % 100) < stall_percent;
            readdata = mem[address[11:2]];   // Zero latency once not stalled
        end
    end

    always @(posedge clk) begin
        if (write && !waitrequest) begin
            mem[address[11:2]] <= writedata;
        end
    end

endmodule

// ==== dv/tb_mips_cpu_bus.sv ====
`timescale 1ns/1ns

module tb_mips_cpu_bus;
    localparam mips_pkg::word_t base = mips_pkg::RESET_VECTOR;
    localparam int timeout_cycles = 5000;

    logic clk;
    logic reset;
    logic active;
    logic read;
    logic write;
    logic waitrequest;
    logic [3:0] byteenable;
    mips_pkg::word_t register_v0;
    mips_pkg::word_t address;
    mips_pkg::word_t writedata;
    mips_pkg::word_t readdata;
    int stall_percent;
    int errors;
    int passed;
    int failed;
    mips_pkg::word_t prog [$];

    mips_cpu_bus mips_cpu_bus_i (.*);

    bus_memory #(.seed(90)) bus_memory_i (.*);

    always #5 clk = ~clk;

    // Word accesses only
    always @(negedge clk) begin
        if ((read || write) && byteenable !== 4'hF)
            report_mismatch("byteenable", byteenable, 32'hF);
    end

    function automatic mips_pkg::word_t itype(input logic [5:0] op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mips_pkg::word_t rtype(input logic [4:0] rs, input logic [4:0] rt,
                                              input logic [4:0] rd, input logic [4:0] sa,
                                              input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic mips_pkg::word_t swap_order(input mips_pkg::word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    task automatic report_mismatch(input string name, input mips_pkg::word_t got,
                                   input mips_pkg::word_t expected);
        $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, expected);
        errors++;
    endtask

    task automatic finish_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            $display("test %s: ok", name);
            passed++;
        end else begin
            $display("test %s: failed", name);
            failed++;
        end
    endtask

    // Appends jr $zero, reloads memory, resets the CPU and waits for the halt
    task automatic run_program(input int stall, output logic halted);
        int cycles;
        prog.push_back(rtype(0, 0, 0, 0, mips_pkg::FN_JR));
        prog.push_back(32'h0000_0000);
        @(negedge clk);
        reset = 1'b1;
        stall_percent = stall;
        bus_memory_i.clear();
        foreach (prog[i]) begin
            bus_memory_i.store_word(base + 4 * i, swap_order(prog[i]));
        end
        repeat (2) @(negedge clk);
        if (read !== 1'b0)
            report_mismatch("read", read, 0);
        reset = 1'b0;
        cycles = 0;
        while (active !== 1'b0 && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        halted = active === 1'b0;
        if (!halted) begin
            $display("ERROR: CPU did not halt within %0d cycles", timeout_cycles);
            errors++;
        end
        prog.delete();
    endtask

    task automatic alu_test(input string name, input int stall, input logic check_halt);
        mips_pkg::word_t r [21];
        mips_pkg::word_t expected;
        logic halted;
        int start_errors;
        start_errors = errors;
        prog.push_back(itype(mips_pkg::OP_ADDIU, 0, 8, 16'hFFFB));
        prog.push_back(itype(mips_pkg::OP_LUI, 0, 9, 16'h1234));
        prog.push_back(itype(mips_pkg::OP_ORI, 9, 9, 16'h5678));
        prog.push_back(rtype(8, 9, 10, 0, mips_pkg::FN_ADDU));
        prog.push_back(rtype(9, 8, 11, 0, mips_pkg::FN_SUBU));
        prog.push_back(rtype(10, 11, 12, 0, mips_pkg::FN_AND));
        prog.push_back(rtype(10, 11, 13, 0, mips_pkg::FN_OR));
        prog.push_back(rtype(12, 13, 14, 0, mips_pkg::FN_XOR));
        prog.push_back(rtype(8, 9, 15, 0, mips_pkg::FN_SLT));
        prog.push_back(rtype(8, 9, 16, 0, mips_pkg::FN_SLTU));
        prog.push_back(rtype(0, 9, 17, 4, mips_pkg::FN_SLL));
        prog.push_back(rtype(0, 8, 18, 8, mips_pkg::FN_SRL));
        prog.push_back(itype(mips_pkg::OP_ANDI, 9, 19, 16'hF0F0));
        prog.push_back(itype(mips_pkg::OP_SLTI, 8, 20, 16'h0000));
        prog.push_back(rtype(14, 15, 2, 0, mips_pkg::FN_ADDU));
        prog.push_back(rtype(2, 16, 2, 0, mips_pkg::FN_ADDU));
        prog.push_back(rtype(2, 17, 2, 0, mips_pkg::FN_XOR));
        prog.push_back(rtype(2, 18, 2, 0, mips_pkg::FN_ADDU));
        prog.push_back(rtype(2, 19, 2, 0, mips_pkg::FN_ADDU));
        prog.push_back(rtype(2, 20, 2, 0, mips_pkg::FN_ADDU));
        run_program(stall, halted);
        r[8] = 32'hFFFF_FFFB;   // Sign-extended -5
        r[9] = 32'h1234_5678;
        r[10] = r[8] + r[9];
        r[11] = r[9] - r[8];
        r[12] = r[10] & r[11];
        r[13] = r[10] | r[11];
        r[14] = r[12] ^ r[13];
        r[15] = {31'd0, $signed(r[8]) < $signed(r[9])};
        r[16] = {31'd0, r[8] < r[9]};
        r[17] = r[9] << 4;
        r[18] = r[8] >> 8;
        r[19] = r[9] & 32'h0000_F0F0;   // Zero-extended immediate
        r[20] = {31'd0, $signed(r[8]) < 0};
        expected = ((r[14] + r[15] + r[16]) ^ r[17]) + r[18] + r[19] + r[20];
        if (halted && register_v0 !== expected)
            report_mismatch("register_v0", register_v0, expected);
        if (halted && check_halt) begin
            for (int i = 0; i < 20; i++) begin
                @(negedge clk);
                if (read !== 1'b0)
                    report_mismatch("read", read, 0);
                if (active !== 1'b0)
                    report_mismatch("active", active, 0);
            end
        end
        finish_test(name, start_errors);
    endtask

    task automatic load_store_test();
        mips_pkg::word_t ptr;
        mips_pkg::word_t stored;
        logic halted;
        int start_errors;
        start_errors = errors;
        ptr = base + 32'h800;
        stored = 32'hA1B2_C3D4 + 32'h11;
        prog.push_back(itype(mips_pkg::OP_LUI, 0, 8, ptr[31:16]));
        prog.push_back(itype(mips_pkg::OP_ORI, 8, 8, ptr[15:0]));
        prog.push_back(itype(mips_pkg::OP_LUI, 0, 9, 16'hA1B2));
        prog.push_back(itype(mips_pkg::OP_ORI, 9, 9, 16'hC3D4));
        prog.push_back(itype(mips_pkg::OP_ADDIU, 9, 9, 16'h0011));
        prog.push_back(itype(mips_pkg::OP_SW, 8, 9, 16'd4));
        prog.push_back(itype(mips_pkg::OP_LW, 8, 2, 16'd4));
        run_program(30, halted);
        ptr = ptr + 4;
        if (halted && register_v0 !== stored)
            report_mismatch("register_v0", register_v0, stored);
        if (halted && bus_memory_i.mem[ptr[11:2]] !== swap_order(stored))
            report_mismatch("memory word", bus_memory_i.mem[ptr[11:2]], swap_order(stored));
        finish_test("load_store", start_errors);
    endtask

    // Each block is branch, delay slot, skipped-if-taken, landing
    task automatic branch_test();
        mips_pkg::word_t expected;
        mips_pkg::word_t branch;
        logic halted;
        int start_errors;
        start_errors = errors;
        expected = 0;
        prog.push_back(itype(mips_pkg::OP_ADDIU, 0, 8, 16'd5));
        prog.push_back(itype(mips_pkg::OP_ADDIU, 0, 9, 16'hFFFD));
        for (int k = 0; k < 9; k++) begin
            case (k)
                0: branch = itype(mips_pkg::OP_BEQ, 8, 8, 16'd2);
                1: branch = itype(mips_pkg::OP_BEQ, 8, 9, 16'd2);
                2: branch = itype(mips_pkg::OP_BNE, 8, 9, 16'd2);
                3: branch = itype(mips_pkg::OP_BNE, 8, 8, 16'd2);
                4: branch = itype(mips_pkg::OP_BGTZ, 8, 0, 16'd2);
                5: branch = itype(mips_pkg::OP_BGTZ, 9, 0, 16'd2);
                6: branch = itype(mips_pkg::OP_BLEZ, 9, 0, 16'd2);
                7: branch = itype(mips_pkg::OP_BLEZ, 8, 0, 16'd2);
                default: branch = itype(mips_pkg::OP_BLEZ, 0, 0, 16'd2);
            endcase
            prog.push_back(branch);
            prog.push_back(itype(mips_pkg::OP_ADDIU, 2, 2, 16'(k + 1)));
            prog.push_back(itype(mips_pkg::OP_ADDIU, 2, 2, 16'h40 << k));
            prog.push_back(itype(mips_pkg::OP_ADDIU, 2, 2, 16'd3));
            expected += k + 1 + 3 + ((k % 2 == 0) ? 0 : (32'h40 << k));   // Even k taken
        end
        run_program(30, halted);
        if (halted && register_v0 !== expected)
            report_mismatch("register_v0", register_v0, expected);
        finish_test("branches", start_errors);
    endtask

    task automatic jump_test();
        mips_pkg::word_t sub_addr;
        mips_pkg::word_t tail_addr;
        mips_pkg::word_t expected;
        logic halted;
        int start_errors;
        start_errors = errors;
        sub_addr = base + 32'h20;
        tail_addr = base + 32'h30;
        prog.push_back({mips_pkg::OP_JAL, sub_addr[27:2]});
        prog.push_back(32'h0000_0000);
        prog.push_back(itype(mips_pkg::OP_LUI, 0, 11, tail_addr[31:16]));
        prog.push_back(itype(mips_pkg::OP_ORI, 11, 11, tail_addr[15:0]));
        prog.push_back(rtype(11, 0, 12, 0, mips_pkg::FN_JALR));
        prog.push_back(32'h0000_0000);
        prog.push_back(itype(mips_pkg::OP_ADDIU, 2, 2, 16'h0700));   // Never reached
        prog.push_back(itype(mips_pkg::OP_ADDIU, 2, 2, 16'h0700));
        prog.push_back(itype(mips_pkg::OP_ADDIU, 0, 2, 16'h0055));   // Subroutine
        prog.push_back(rtype(31, 0, 0, 0, mips_pkg::FN_JR));
        prog.push_back(32'h0000_0000);
        prog.push_back(32'h0000_0000);
        prog.push_back(rtype(2, 12, 2, 0, mips_pkg::FN_ADDU));
        prog.push_back(rtype(2, 31, 2, 0, mips_pkg::FN_ADDU));
        run_program(30, halted);
        // Link is the jump's own address plus 4
        expected = 32'h55 + (base + 32'd20) + (base + 32'd4);
        if (halted && register_v0 !== expected)
            report_mismatch("register_v0", register_v0, expected);
        finish_test("jal_jr_jalr", start_errors);
    endtask

    task automatic zero_reg_test();
        logic halted;
        int start_errors;
        start_errors = errors;
        prog.push_back(itype(mips_pkg::OP_ADDIU, 0, 2, 16'd9));
        prog.push_back(itype(mips_pkg::OP_ADDIU, 0, 0, 16'h0077));
        prog.push_back(rtype(0, 0, 2, 0, mips_pkg::FN_ADDU));
        run_program(30, halted);
        if (halted && register_v0 !== 32'd0)
            report_mismatch("register_v0", register_v0, 32'd0);
        finish_test("zero_register", start_errors);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        stall_percent = 0;
        errors = 0;
        passed = 0;
        failed = 0;
        alu_test("alu", 30, 1'b0);
        load_store_test();
        branch_test();
        jump_test();
        alu_test("stall_halt", 85, 1'b1);
        zero_reg_test();
        $display("%0d tests passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== files.f ====
common/mips_pkg.sv
hdl/alu.sv
hdl/bus_port.sv
hdl/cpu_fsm.sv
hdl/instr_decode.sv
hdl/pc_counter.sv
hdl/reg_file.sv
hdl/mips_cpu_bus.sv
dv/bus_memory.sv
dv/tb_mips_cpu_bus.sv
